/* Bender.yml */
package:
  name: bd_be_director

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/bd_fe_if_pkg.sv
      - rtl/bd_be_pkg.sv
      - rtl/bd_branch_resolve.sv
      - rtl/bd_director.sv
      - rtl/bd_fe_cmd_queue.sv
      - rtl/bd_be_director_top.sv

  - target: test
    files:
      - dv/bd_be_director_properties.sv
      - dv/bd_be_director_tb.sv

/* build.f */
+incdir+rtl
rtl/bd_fe_if_pkg.sv
rtl/bd_be_pkg.sv
rtl/bd_branch_resolve.sv
rtl/bd_director.sv
rtl/bd_fe_cmd_queue.sv
rtl/bd_be_director_top.sv
dv/bd_be_director_properties.sv
dv/bd_be_director_tb.sv

/* dv/bd_be_director_properties.sv */
`timescale 1ns/1ps

module bd_be_director_properties
  (
    input                             clk_i,
    input                             reset_i,
    input                             fe_cmd_yumi_i,
    input                             fe_cmd_v_i,
    input                             suppress_iss_i,
    input                             poison_isd_i,
    input bd_be_pkg::isd_status_s     isd_status_i,
    input bd_be_pkg::director_state_e state_i
  );

  // Front end pops only what is offered
  yumi_with_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                      fe_cmd_yumi_i |-> fe_cmd_v_i)
    else $error("yumi asserted while no command is valid");

  quiet_in_reset_a: assert property (@(posedge clk_i)
                                     reset_i |=> (!fe_cmd_v_i && !suppress_iss_i))
    else $error("command valid or issue suppression right after a reset cycle");

  suppress_state_a: assert property (@(posedge clk_i) disable iff (reset_i)
    suppress_iss_i |-> (state_i inside {bd_be_pkg::e_fence, bd_be_pkg::e_wfi}))
    else $error("issue suppressed outside the fence and wfi states");

  // Poison only makes sense on an issuing instruction
  poison_on_issue_a: assert property (@(posedge clk_i) disable iff (reset_i)
                                      poison_isd_i |-> isd_status_i.v)
    else $error("poison raised with no valid issue");

endmodule

bind bd_be_director_top bd_be_director_properties u_properties
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fe_cmd_yumi_i  (fe_cmd_yumi_i),
    .fe_cmd_v_i     (fe_cmd_v_o),
    .suppress_iss_i (suppress_iss_o),
    .poison_isd_i   (poison_isd_o),
    .isd_status_i   (isd_status_i),
    .state_i        (u_director.state_r)
  );

/* dv/bd_be_director_tb.sv */
`timescale 1ns/1ps

`include "bd_defines.svh"

module bd_be_director_tb;

  // One table row of stimulus and expected response
  typedef struct packed
  {
    bd_be_pkg::exe_pkt_s        exe;
    bd_be_pkg::isd_status_s     isd;
    bd_be_pkg::commit_pkt_s     commit;
    logic                       irq;
    logic                       freeze;
    logic                       bp;
    logic                       exp_cmd_v;
    bd_fe_if_pkg::fe_cmd_s      exp_cmd;
    logic                       exp_poison;
    logic [`BD_VADDR_WIDTH-1:0] exp_npc;
    logic                       exp_full;
    logic                       exp_supp;
  } row_s;

  logic                       clk_i;
  logic                       reset_i;
  logic                       freeze_i;
  logic                       irq_waiting_i;
  bd_be_pkg::exe_pkt_s        exe_i;
  bd_be_pkg::isd_status_s     isd_status_i;
  bd_be_pkg::commit_pkt_s     commit_pkt_i;
  logic                       fe_cmd_yumi_i;
  logic [`BD_VADDR_WIDTH-1:0] expected_npc_o;
  logic                       poison_isd_o;
  logic                       suppress_iss_o;
  bd_fe_if_pkg::fe_cmd_s      fe_cmd_o;
  logic                       fe_cmd_v_o;
  logic                       fe_cmd_full_o;

  integer                     seed = 32'he4d;
  row_s                       rows[$];
  string                      names[$];
  bd_fe_if_pkg::fe_cmd_s      pend_cmd[$];
  string                      pend_name[$];

  bd_be_director_top UUT
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .freeze_i       (freeze_i),
    .irq_waiting_i  (irq_waiting_i),
    .exe_i          (exe_i),
    .isd_status_i   (isd_status_i),
    .commit_pkt_i   (commit_pkt_i),
    .fe_cmd_yumi_i  (fe_cmd_yumi_i),
    .expected_npc_o (expected_npc_o),
    .poison_isd_o   (poison_isd_o),
    .suppress_iss_o (suppress_iss_o),
    .fe_cmd_o       (fe_cmd_o),
    .fe_cmd_v_o     (fe_cmd_v_o),
    .fe_cmd_full_o  (fe_cmd_full_o)
  );

  always
  begin
    #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_fe_cmd(input string name, input bd_fe_if_pkg::fe_cmd_s exp,
                              input bd_fe_if_pkg::fe_cmd_s act);
    if (act !== exp)
      abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_npc(input string name, input logic [`BD_VADDR_WIDTH-1:0] exp,
                           input logic [`BD_VADDR_WIDTH-1:0] act);
    if (act !== exp)
      abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // Branch rule, blt and bge signed, jal always taken
  function automatic logic branch_taken(input bd_be_pkg::branch_op_e op,
                                        input logic [31:0] a, input logic [31:0] b);
    case (op)
      bd_be_pkg::e_beq: return a == b;
      bd_be_pkg::e_bne: return a != b;
      bd_be_pkg::e_blt: return $signed(a) < $signed(b);
      bd_be_pkg::e_bge: return !($signed(a) < $signed(b));
      bd_be_pkg::e_jal: return 1'b1;
      default:          return 1'b0;
    endcase
  endfunction

  task automatic add_row(input string name, input row_s r);
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_branch_row(input string name, input bd_be_pkg::branch_op_e op,
                                input logic mispredict, input logic bp,
                                input logic exp_cmd_v, input logic exp_full);
    row_s        r;
    logic        taken;
    logic [31:0] npc;
    logic [31:0] rnd;
    r              = '0;
    r.exe.v        = 1'b1;
    r.exe.is_branch = 1'b1;
    r.exe.op       = op;
    r.exe.pc       = next_rand() & 32'hffff_fffc;
    r.exe.rs1      = next_rand();
    // Half the time equal operands so beq and bne both go each way
    r.exe.rs2      = next_rand() & 32'h1 ? r.exe.rs1 : next_rand();
    r.exe.imm      = next_rand() & 32'h0000_0ffc;
    taken          = branch_taken(op, r.exe.rs1, r.exe.rs2);
    npc            = taken ? r.exe.pc + r.exe.imm : r.exe.pc + 32'd4;
    rnd            = next_rand();
    r.isd.v        = 1'b1;
    r.isd.meta     = rnd[7:0];
    r.isd.pc       = mispredict ? npc + 32'd8 : npc;
    r.bp           = bp;
    r.exp_cmd_v    = exp_cmd_v;
    r.exp_poison   = mispredict;
    r.exp_npc      = npc;
    r.exp_full     = exp_full;
    r.exp_cmd.vaddr = npc;
    r.exp_cmd.meta = rnd[7:0];
    if (mispredict)
    begin
      r.exp_cmd.opcode = bd_fe_if_pkg::e_op_pc_redirect;
      r.exp_cmd.subop  = bd_fe_if_pkg::e_subop_branch_mispredict;
      r.exp_cmd.reason = taken ? bd_fe_if_pkg::e_incorrect_pred_taken
                               : bd_fe_if_pkg::e_incorrect_pred_ntaken;
    end
    else
    begin
      r.exp_cmd.opcode = bd_fe_if_pkg::e_op_attaboy;
      r.exp_cmd.taken  = taken;
    end
    add_row(name, r);
  endtask

  // Flags are {exception, interrupt, eret, wfi, fencei, icache_miss}
  task automatic add_commit_row(input string name, input logic [5:0] flags,
                                input logic [31:0] npc, input logic irq,
                                input bd_fe_if_pkg::fe_cmd_opcode_e op,
                                input bd_fe_if_pkg::fe_cmd_subop_e subop, input logic supp);
    row_s r;
    r = '0;
    {r.commit.exception, r.commit.interrupt, r.commit.eret, r.commit.wfi,
     r.commit.fencei, r.commit.icache_miss} = flags;
    r.commit.npc_w_v = 1'b1;
    r.commit.npc     = npc;
    r.irq            = irq;
    r.exp_npc        = npc;
    r.exp_cmd_v      = 1'b1;
    r.exp_cmd.opcode = op;
    r.exp_cmd.vaddr  = npc;
    r.exp_cmd.subop  = subop;
    r.exp_supp       = supp;
    add_row(name, r);
  endtask

  task automatic build_table();
    row_s r;
    r                = '0;
    r.exp_npc        = `BD_BOOT_PC;
    r.exp_cmd_v      = 1'b1;
    r.exp_cmd.opcode = bd_fe_if_pkg::e_op_state_reset;
    r.exp_cmd.vaddr  = `BD_BOOT_PC;
    add_row("boot", r);
    for (int k = 0; k < 10; k++)
      add_branch_row($sformatf("%s_%0d", (k < 5) ? "attaboy" : "mispredict", k % 5),
                     bd_be_pkg::branch_op_e'(k % 5), k >= 5, 1'b0, 1'b1, 1'b0);
    add_commit_row("prio_fencei", 6'b101011, 32'h2000, 1'b0,
                   bd_fe_if_pkg::e_op_icache_fence, bd_fe_if_pkg::e_subop_trap, 1'b0);
    add_commit_row("prio_icache_miss", 6'b011001, 32'h2100, 1'b0,
                   bd_fe_if_pkg::e_op_icache_fill_response, bd_fe_if_pkg::e_subop_trap, 1'b0);
    add_commit_row("prio_eret", 6'b111000, 32'h2200, 1'b0,
                   bd_fe_if_pkg::e_op_pc_redirect, bd_fe_if_pkg::e_subop_eret, 1'b0);
    add_commit_row("prio_trap", 6'b110000, 32'h2300, 1'b0,
                   bd_fe_if_pkg::e_op_pc_redirect, bd_fe_if_pkg::e_subop_trap, 1'b0);
    add_commit_row("wfi_wait", 6'b100110, 32'h2400, 1'b0,
                   bd_fe_if_pkg::e_op_wait, bd_fe_if_pkg::e_subop_trap, 1'b1);
    add_commit_row("wfi_wake", 6'b000000, 32'h0300, 1'b1,
                   bd_fe_if_pkg::e_op_pc_redirect, bd_fe_if_pkg::e_subop_trap, 1'b0);
    // Fifth attaboy meets a full queue and is lost
    for (int k = 0; k < 5; k++)
      add_branch_row($sformatf("backpressure_%0d", k), bd_be_pkg::branch_op_e'(k),
                     1'b0, 1'b1, k < 4, k == 4);
  endtask

  task automatic pop_fe_cmd(input string name, input bd_fe_if_pkg::fe_cmd_s exp);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!fe_cmd_v_o)
    begin
      cycles++;
      if (cycles > 20)
        abort_run($sformatf("%s: no front-end command arrived", name));
      @(negedge clk_i);
    end
    check_fe_cmd(name, exp, fe_cmd_o);
    @(posedge clk_i);
    fe_cmd_yumi_i <= 1'b1;
    @(posedge clk_i);
    fe_cmd_yumi_i <= 1'b0;
  endtask

  // Exe first, issue and commit one cycle later when the branch packet is valid
  task automatic apply_row(input int i);
    row_s r;
    r = rows[i];
    @(posedge clk_i);
    exe_i    <= r.exe;
    freeze_i <= r.freeze;
    @(posedge clk_i);
    exe_i         <= '0;
    isd_status_i  <= r.isd;
    commit_pkt_i  <= r.commit;
    irq_waiting_i <= r.irq;
    @(negedge clk_i);
    check_npc({names[i], " npc"}, r.exp_npc, expected_npc_o);
    check_flag({names[i], " poison"}, r.exp_poison, poison_isd_o);
    check_flag({names[i], " full"}, r.exp_full, fe_cmd_full_o);
    @(posedge clk_i);
    isd_status_i  <= '0;
    commit_pkt_i  <= '0;
    irq_waiting_i <= 1'b0;
    if (r.exp_cmd_v && r.bp)
    begin
      pend_cmd.push_back(r.exp_cmd);
      pend_name.push_back(names[i]);
    end
    else if (r.exp_cmd_v)
      pop_fe_cmd(names[i], r.exp_cmd);
    @(negedge clk_i);
    check_flag({names[i], " suppress"}, r.exp_supp, suppress_iss_o);
    // Next PC register keeps the written value once the update is gone
    check_npc({names[i], " npc held"}, r.exp_npc, expected_npc_o);
    if (!r.bp)
      check_flag({names[i], " leftover"}, 1'b0, fe_cmd_v_o);
  endtask

  initial
  begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    freeze_i      = 1'b1;
    irq_waiting_i = 1'b0;
    exe_i         = '0;
    isd_status_i  = '0;
    commit_pkt_i  = '0;
    fe_cmd_yumi_i = 1'b0;
    build_table();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_flag("reset cmd valid", 1'b0, fe_cmd_v_o);
    check_flag("reset poison", 1'b0, poison_isd_o);
    check_flag("reset suppress", 1'b0, suppress_iss_o);
    check_npc("reset npc", `BD_BOOT_PC, expected_npc_o);
    for (int i = 0; i < rows.size(); i++)
      apply_row(i);
    // Release the front end, queued attaboys drain in order
    while (pend_cmd.size() != 0)
      pop_fe_cmd(pend_name.pop_front(), pend_cmd.pop_front());
    @(negedge clk_i);
    check_flag("drain cmd valid", 1'b0, fe_cmd_v_o);
    check_flag("drain full", 1'b0, fe_cmd_full_o);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* rtl/bd_be_director_top.sv */
`timescale 1ns/1ps

`include "bd_defines.svh"

module bd_be_director_top
  (
    input                              clk_i,
    input                              reset_i,
    input                              freeze_i,
    input                              irq_waiting_i,
    input  bd_be_pkg::exe_pkt_s        exe_i,
    input  bd_be_pkg::isd_status_s     isd_status_i,
    input  bd_be_pkg::commit_pkt_s     commit_pkt_i,
    input                              fe_cmd_yumi_i,
    output logic [`BD_VADDR_WIDTH-1:0] expected_npc_o,
    output logic                       poison_isd_o,
    output logic                       suppress_iss_o,
    output bd_fe_if_pkg::fe_cmd_s      fe_cmd_o,
    output logic                       fe_cmd_v_o,
    output logic                       fe_cmd_full_o
  );

  bd_be_pkg::branch_pkt_s br_pkt;
  bd_fe_if_pkg::fe_cmd_s  dir_cmd;
  logic                   dir_cmd_v;
  logic                   queue_ready;

  bd_branch_resolve u_branch_resolve
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .exe_i    (exe_i),
    .br_pkt_o (br_pkt)
  );

  bd_director u_director
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .freeze_i       (freeze_i),
    .irq_waiting_i  (irq_waiting_i),
    .isd_status_i   (isd_status_i),
    .br_pkt_i       (br_pkt),
    .commit_pkt_i   (commit_pkt_i),
    .queue_ready_i  (queue_ready),
    .queue_v_i      (fe_cmd_v_o),
    .expected_npc_o (expected_npc_o),
    .poison_isd_o   (poison_isd_o),
    .suppress_iss_o (suppress_iss_o),
    .cmd_o          (dir_cmd),
    .cmd_v_o        (dir_cmd_v)
  );

  bd_fe_cmd_queue u_fe_cmd_queue
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_i         (dir_cmd),
    .cmd_v_i       (dir_cmd_v),
    .fe_cmd_yumi_i (fe_cmd_yumi_i),
    .ready_o       (queue_ready),
    .fe_cmd_o      (fe_cmd_o),
    .fe_cmd_v_o    (fe_cmd_v_o)
  );

  assign fe_cmd_full_o = ~queue_ready;

endmodule

/* rtl/bd_be_pkg.sv */
`include "bd_defines.svh"

package bd_be_pkg;

  typedef enum logic [2:0]
  {
    e_beq = 3'd0,
    e_bne = 3'd1,
    e_blt = 3'd2,
    e_bge = 3'd3,
    e_jal = 3'd4
  } branch_op_e;

  // Operands of the instruction in the resolve stage
  typedef struct packed
  {
    logic                       v;
    logic [`BD_VADDR_WIDTH-1:0] pc;
    branch_op_e                 op;
    logic [`BD_VADDR_WIDTH-1:0] rs1;
    logic [`BD_VADDR_WIDTH-1:0] rs2;
    logic [`BD_VADDR_WIDTH-1:0] imm;
    logic                       is_branch;
  } exe_pkt_s;

  // Instruction issuing this cycle
  typedef struct packed
  {
    logic                       v;
    logic [`BD_VADDR_WIDTH-1:0] pc;
    logic [`BD_META_WIDTH-1:0]  meta;
  } isd_status_s;

  typedef struct packed
  {
    logic                       v;
    logic                       branch;
    logic                       btaken;
    logic [`BD_VADDR_WIDTH-1:0] npc;
  } branch_pkt_s;

  typedef struct packed
  {
    logic                       npc_w_v;
    logic [`BD_VADDR_WIDTH-1:0] npc;
    logic                       exception;
    logic                       interrupt;
    logic                       eret;
    logic                       wfi;
    logic                       fencei;
    logic                       icache_miss;
  } commit_pkt_s;

  typedef enum logic [2:0]
  {
    e_reset = 3'd0,
    e_boot  = 3'd1,
    e_run   = 3'd2,
    e_fence = 3'd3,
    e_wfi   = 3'd4
  } director_state_e;

endpackage

/* rtl/bd_branch_resolve.sv */
`timescale 1ns/1ps

`include "bd_defines.svh"

module bd_branch_resolve
  (
    input                          clk_i,
    input                          reset_i,
    input  bd_be_pkg::exe_pkt_s    exe_i,
    output bd_be_pkg::branch_pkt_s br_pkt_o
  );

  logic                       cond_taken;
  logic                       taken;
  logic [`BD_VADDR_WIDTH-1:0] npc_n;

  logic                       v_r;
  logic                       branch_r;
  logic                       btaken_r;
  logic [`BD_VADDR_WIDTH-1:0] npc_r;

  // Branch condition, blt/bge compare as signed
  always_comb
  begin
    case (exe_i.op)
      bd_be_pkg::e_beq: cond_taken = (exe_i.rs1 == exe_i.rs2);
      bd_be_pkg::e_bne: cond_taken = (exe_i.rs1 != exe_i.rs2);
      bd_be_pkg::e_blt: cond_taken = ($signed(exe_i.rs1) < $signed(exe_i.rs2));
      bd_be_pkg::e_bge: cond_taken = ($signed(exe_i.rs1) >= $signed(exe_i.rs2));
      bd_be_pkg::e_jal: cond_taken = 1'b1;
      default:          cond_taken = 1'b0;
    endcase
  end

  // Non-branches always fall through
  assign taken = exe_i.is_branch & cond_taken;
  assign npc_n = taken ? (exe_i.pc + exe_i.imm) : (exe_i.pc + `BD_VADDR_WIDTH'(4));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_r <= 1'b0;
    end
    else
    begin
      v_r <= exe_i.v;
    end
  end

  always_ff @(posedge clk_i)
  begin
    branch_r <= exe_i.is_branch;
    btaken_r <= taken;
    npc_r    <= npc_n;
  end

  assign br_pkt_o.v      = v_r;
  assign br_pkt_o.branch = branch_r;
  assign br_pkt_o.btaken = btaken_r;
  assign br_pkt_o.npc    = npc_r;

endmodule

/* rtl/bd_defines.svh */
`ifndef BD_DEFINES_SVH
`define BD_DEFINES_SVH

// Virtual address width shared by the front-end and back-end packets
`define BD_VADDR_WIDTH 32

// Opaque branch metadata passed through from fetch
`define BD_META_WIDTH 8

// First PC fetched after reset
`define BD_BOOT_PC 32'h0000_1000

// Front-end command queue depth
`define BD_FE_CMD_ELS 4

`endif

/* rtl/bd_director.sv */
`timescale 1ns/1ps

`include "bd_defines.svh"

module bd_director
  (
    input                              clk_i,
    input                              reset_i,
    input                              freeze_i,
    input                              irq_waiting_i,
    input  bd_be_pkg::isd_status_s     isd_status_i,
    input  bd_be_pkg::branch_pkt_s     br_pkt_i,
    input  bd_be_pkg::commit_pkt_s     commit_pkt_i,
    input                              queue_ready_i,
    input                              queue_v_i,
    output logic [`BD_VADDR_WIDTH-1:0] expected_npc_o,
    output logic                       poison_isd_o,
    output logic                       suppress_iss_o,
    output bd_fe_if_pkg::fe_cmd_s      cmd_o,
    output logic                       cmd_v_o
  );

  bd_be_pkg::director_state_e state_r;
  bd_be_pkg::director_state_e state_n;

  logic [`BD_VADDR_WIDTH-1:0] npc_r;
  logic [`BD_VADDR_WIDTH-1:0] npc_n;
  logic                       npc_w_v;
  logic                       npc_mismatch_v;
  logic                       br_branch_v;
  logic                       branch_pending_r;
  logic                       btaken_pending_r;
  logic                       last_was_branch;
  logic                       last_was_btaken;
  logic                       cmd_gen_v;
  logic                       cmd_nonattaboy_v;
  bd_fe_if_pkg::fe_cmd_s      cmd_n;

  // Commit write wins over the resolved branch
  assign npc_w_v = commit_pkt_i.npc_w_v | br_pkt_i.v;
  assign npc_n   = commit_pkt_i.npc_w_v ? commit_pkt_i.npc : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      npc_r <= `BD_BOOT_PC;
    end
    else if (npc_w_v)
    begin
      npc_r <= npc_n;
    end
  end

  // Forward the pending update so issue sees it this cycle
  assign expected_npc_o = npc_w_v ? npc_n : npc_r;
  assign npc_mismatch_v = isd_status_i.v & (expected_npc_o != isd_status_i.pc);
  assign poison_isd_o   = npc_mismatch_v;

  // Remember the last branch until the next instruction issues
  assign br_branch_v = br_pkt_i.v & br_pkt_i.branch;

  always_ff @(posedge clk_i)
  begin
    if (reset_i || isd_status_i.v)
    begin
      branch_pending_r <= 1'b0;
      btaken_pending_r <= 1'b0;
    end
    else if (br_branch_v)
    begin
      branch_pending_r <= 1'b1;
      btaken_pending_r <= br_pkt_i.btaken;
    end
  end

  assign last_was_branch = branch_pending_r | br_branch_v;
  assign last_was_btaken = btaken_pending_r | (br_branch_v & br_pkt_i.btaken);

  // One command per cycle, highest priority first
  always_comb
  begin
    cmd_n     = '0;
    cmd_gen_v = 1'b0;

    if (state_r == bd_be_pkg::e_reset)
    begin
      cmd_gen_v = 1'b0;
    end
    else if (state_r == bd_be_pkg::e_boot)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_state_reset;
      cmd_n.vaddr  = npc_r;
      cmd_gen_v    = 1'b1;
    end
    else if (commit_pkt_i.wfi)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_wait;
      cmd_n.vaddr  = commit_pkt_i.npc;
      cmd_gen_v    = 1'b1;
    end
    else if (commit_pkt_i.fencei)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_icache_fence;
      cmd_n.vaddr  = commit_pkt_i.npc;
      cmd_gen_v    = 1'b1;
    end
    else if (commit_pkt_i.icache_miss)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_icache_fill_response;
      cmd_n.vaddr  = commit_pkt_i.npc;
      cmd_gen_v    = 1'b1;
    end
    else if (commit_pkt_i.eret)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_pc_redirect;
      cmd_n.vaddr  = commit_pkt_i.npc;
      cmd_n.subop  = bd_fe_if_pkg::e_subop_eret;
      cmd_gen_v    = 1'b1;
    end
    else if (commit_pkt_i.exception || commit_pkt_i.interrupt
             || (state_r == bd_be_pkg::e_wfi && irq_waiting_i))
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_pc_redirect;
      cmd_n.vaddr  = commit_pkt_i.npc;
      cmd_n.subop  = bd_fe_if_pkg::e_subop_trap;
      cmd_gen_v    = 1'b1;
    end
    else if (npc_mismatch_v)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_pc_redirect;
      cmd_n.vaddr  = expected_npc_o;
      cmd_n.subop  = bd_fe_if_pkg::e_subop_branch_mispredict;
      cmd_n.meta   = isd_status_i.meta;
      if (!last_was_branch)
        cmd_n.reason = bd_fe_if_pkg::e_not_a_branch;
      else if (last_was_btaken)
        cmd_n.reason = bd_fe_if_pkg::e_incorrect_pred_taken;
      else
        cmd_n.reason = bd_fe_if_pkg::e_incorrect_pred_ntaken;
      cmd_gen_v    = 1'b1;
    end
    // Correct prediction after a branch
    else if (isd_status_i.v && last_was_branch)
    begin
      cmd_n.opcode = bd_fe_if_pkg::e_op_attaboy;
      cmd_n.vaddr  = expected_npc_o;
      cmd_n.taken  = last_was_btaken;
      cmd_n.meta   = isd_status_i.meta;
      cmd_gen_v    = 1'b1;
    end
  end

  // A full queue drops the command
  assign cmd_o            = cmd_n;
  assign cmd_v_o          = cmd_gen_v & queue_ready_i;
  assign cmd_nonattaboy_v = cmd_v_o & (cmd_n.opcode != bd_fe_if_pkg::e_op_attaboy);

  always_comb
  begin
    case (state_r)
      bd_be_pkg::e_reset: state_n = freeze_i ? bd_be_pkg::e_reset : bd_be_pkg::e_boot;
      bd_be_pkg::e_boot:  state_n = cmd_v_o ? bd_be_pkg::e_run : bd_be_pkg::e_boot;
      bd_be_pkg::e_run:
      begin
        if (commit_pkt_i.wfi)
          state_n = bd_be_pkg::e_wfi;
        else if (cmd_nonattaboy_v)
          state_n = bd_be_pkg::e_fence;
        else
          state_n = bd_be_pkg::e_run;
      end
      // Wait for fetch to drain the queue
      bd_be_pkg::e_fence: state_n = queue_v_i ? bd_be_pkg::e_fence : bd_be_pkg::e_run;
      bd_be_pkg::e_wfi:   state_n = cmd_nonattaboy_v ? bd_be_pkg::e_fence : bd_be_pkg::e_wfi;
      default:            state_n = bd_be_pkg::e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= bd_be_pkg::e_reset;
    else
      state_r <= state_n;
  end

  assign suppress_iss_o = ((state_r == bd_be_pkg::e_fence) & queue_v_i)
                          | (state_r == bd_be_pkg::e_wfi);

endmodule

/* rtl/bd_fe_cmd_queue.sv */
`timescale 1ns/1ps

`include "bd_defines.svh"

module bd_fe_cmd_queue
  (
    input                         clk_i,
    input                         reset_i,
    input  bd_fe_if_pkg::fe_cmd_s cmd_i,
    input                         cmd_v_i,
    input                         fe_cmd_yumi_i,
    output logic                  ready_o,
    output bd_fe_if_pkg::fe_cmd_s fe_cmd_o,
    output logic                  fe_cmd_v_o
  );

  localparam int els_lp       = `BD_FE_CMD_ELS;
  localparam int ptr_width_lp = (els_lp > 1) ? $clog2(els_lp) : 1;
  localparam int cnt_width_lp = $clog2(els_lp + 1);

  bd_fe_if_pkg::fe_cmd_s   mem_r [els_lp];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    enq;
  logic                    deq;

  assign ready_o    = (count_r != cnt_width_lp'(els_lp));
  assign fe_cmd_v_o = (count_r != '0);
  assign fe_cmd_o   = mem_r[rptr_r];

  assign enq = cmd_v_i & ready_o;
  assign deq = fe_cmd_yumi_i & fe_cmd_v_o;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= cmd_i;
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq)
        wptr_r <= (wptr_r == ptr_width_lp'(els_lp - 1)) ? '0 : wptr_r + 1'b1;
      if (deq)
        rptr_r <= (rptr_r == ptr_width_lp'(els_lp - 1)) ? '0 : rptr_r + 1'b1;
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

/* rtl/bd_fe_if_pkg.sv */
`include "bd_defines.svh"

package bd_fe_if_pkg;

  // Command kinds sent from the back end to fetch
  typedef enum logic [2:0]
  {
    e_op_state_reset          = 3'd0,
    e_op_pc_redirect          = 3'd1,
    e_op_icache_fence         = 3'd2,
    e_op_icache_fill_response = 3'd3,
    e_op_wait                 = 3'd4,
    e_op_attaboy              = 3'd5
  } fe_cmd_opcode_e;

  // Why a pc_redirect was issued
  typedef enum logic [1:0]
  {
    e_subop_trap              = 2'd0,
    e_subop_eret              = 2'd1,
    e_subop_branch_mispredict = 2'd2
  } fe_cmd_subop_e;

  // Only meaningful with branch_mispredict
  typedef enum logic [1:0]
  {
    e_not_a_branch          = 2'd0,
    e_incorrect_pred_taken  = 2'd1,
    e_incorrect_pred_ntaken = 2'd2
  } mispredict_reason_e;

  // One front-end command
  typedef struct packed
  {
    fe_cmd_opcode_e             opcode;
    logic [`BD_VADDR_WIDTH-1:0] vaddr;
    fe_cmd_subop_e              subop;
    mispredict_reason_e         reason;
    // Attaboy direction
    logic                       taken;
    logic [`BD_META_WIDTH-1:0]  meta;
  } fe_cmd_s;

endpackage
